// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fp16CvtTb
FILELIST  := list.f

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== cntlz16Reg.sv ====
`timescale 1ns/1ps

module cntlz16Reg import fp16Pkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  logic       ce,
	input  intWord     i,
	output logic [4:0] o	// leading zeros or 16 for zero
);

	logic [4:0] cnt;	// combinational count

	// ==================================================
	// priority search
	// ==================================================
	// scan upward so the highest set bit wins
	always_comb begin
		cnt = 5'(FPWID);	// all zero
		for (int k = 0; k < FPWID; k++) begin
			if (i[k])
				cnt = 5'(MSB - k);
		end
	end

	// registered on the same edge as the operand staging
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			o <= '0;
		else if (ce)
			o <= cnt;
	end

endmodule

// ==== delay1.sv ====
`timescale 1ns/1ps

// single pipeline register for every input stage
module delay1 #(
	parameter int WID = 1
) (
	input  logic           clk,
	input  logic           arstN,
	input  logic           ce,
	input  logic [WID-1:0] i,
	output logic [WID-1:0] o
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			o <= '0;
		else if (ce)
			o <= i;	// hold when ce low
	end

endmodule

// ==== f2i16.sv ====
`timescale 1ns/1ps

module f2i16 import fp16Pkg::*; (
	input  logic     clk,
	input  logic     arstN,
	input  logic     ce,
	input  logic     sgn,	// signed result range
	input  roundMode rm,
	input  fpHalf    i,
	output intWord   o
);

	logic [2:0]                  rmd;
	logic                        sgnd;	// staged signed flag
	fpHalf                       fd;	// staged float
	logic [EMSB:0]               eEff;	// subnormals use exponent 1
	logic [FMSB+1:0]             sig;	// significand with hidden bit
	logic [FPWID+fixFrac-1:0]    fixed;	// 16.24 fixed point magnitude
	logic [MSB:0]                intPart;
	logic                        rnd;
	logic [FPWID:0]              magR;	// rounded with one spare bit
	logic                        isInfNan;
	logic                        isNan;
	intWord                      posLim;
	intWord                      negLim;
	logic                        ovfPos;
	logic                        ovfNeg;

	// ==================================================
	// input stage
	// ==================================================
	delay1 #(.WID(3))     uRm    (.clk(clk), .arstN(arstN), .ce(ce), .i(rm),  .o(rmd));
	delay1 #(.WID(1))     uSgnd  (.clk(clk), .arstN(arstN), .ce(ce), .i(sgn), .o(sgnd));
	delay1 #(.WID(FPWID)) uFloat (.clk(clk), .arstN(arstN), .ce(ce), .i(i),   .o(fd));

	// ==================================================
	// align to fixed point
	// ==================================================
	assign eEff = (fd.expo == '0) ? {{EMSB{1'b0}}, 1'b1} : fd.expo;
	assign sig  = {fd.expo != '0, fd.frac};

	// sig lsb weighs 2^(eEff-25) and fixed lsb weighs 2^-24
	assign fixed   = {{(FPWID+expBias-2){1'b0}}, sig} << (eEff - {{EMSB{1'b0}}, 1'b1});
	assign intPart = fixed[FPWID+fixFrac-1 -: FPWID];

	assign rnd = roundUp(roundMode'(rmd), fd.sign,
		fixed[fixFrac],	// kept lsb
		fixed[fixFrac-1],	// half bit
		|fixed[fixFrac-2:0]);
	assign magR = {1'b0, intPart} + {{FPWID{1'b0}}, rnd};

	// ==================================================
	// saturation
	// ==================================================
	assign isInfNan = fd.expo == expMax[EMSB:0];
	assign isNan    = isInfNan & (|fd.frac);

	assign posLim = sgnd ? {1'b0, {MSB{1'b1}}} : '1;	// 32767 or 65535
	assign negLim = sgnd ? {1'b1, {MSB{1'b0}}} : '0;	// -32768 or 0

	assign ovfPos = sgnd ? (magR > {2'b00, {MSB{1'b1}}}) : magR[FPWID];
	assign ovfNeg = sgnd ? (magR > {2'b01, {MSB{1'b0}}}) : (magR != '0);	// any neg when unsigned

	always_comb begin
		if (isNan)
			o = posLim;	// nan goes positive
		else if (isInfNan)
			o = fd.sign ? negLim : posLim;
		else if (fd.sign)
			o = ovfNeg ? negLim : -magR[MSB:0];	// -0 still 0
		else
			o = ovfPos ? posLim : magR[MSB:0];
	end

endmodule

// ==== fp16CvtTb.sv ====
`timescale 1ns/1ps

module fp16CvtTb import fp16Pkg::*; ();

	logic        clk;
	logic        arstN;
	logic        ce;
	cvtOp        op;
	logic        sgn;
	roundMode    rm;
	logic [15:0] a;
	logic [15:0] o;
	int          errCount;	// wrong values
	int          timeoutCount;	// waits that ran out
	logic [31:0] rngState;

	fp16CvtUnit u_dut (
		.clk(clk), .arstN(arstN), .ce(ce),
		.op(op), .sgn(sgn), .rm(rm),
		.a(a), .o(o)
	);

	bind fp16CvtUnit fp16CvtUnit_checker uChk (
		.clk(clk), .arstN(arstN), .ce(ce), .op(op), .a(a), .o(o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	// ==================================================
	// reference model
	// ==================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic fpHalf modelI2F(input intWord v, input logic s, input roundMode m);
		logic        neg;
		logic [15:0] mag;
		int          p;	// position of leading one
		int          e;
		int          sh;
		int          fr;
		logic        up;
		neg = s & v[15];
		mag = neg ? 16'(-v) : v;
		if (mag == 16'd0)
			return '0;
		p = 0;
		for (int k = 0; k < 16; k++) begin
			if (mag[k])
				p = k;
		end
		e = expBias + p;
		if (p <= FMSB + 1) begin
			fr = int'(mag) << (FMSB + 1 - p);	// exact with nothing dropped
		end else begin
			sh = p - (FMSB + 1);
			fr = int'(mag) >> sh;
			up = roundUp(m, neg, fr[0], mag[sh-1], (int'(mag) & ((1 << (sh - 1)) - 1)) != 0);
			fr = fr + int'(up);
		end
		fr = fr - (1 << (FMSB + 1));	// strip hidden one
		if (fr == (1 << (FMSB + 1))) begin	// fraction overflow
			fr = 0;
			e = e + 1;
		end
		return {neg, 5'(e), 10'(fr)};
	endfunction

	function automatic intWord modelF2I(input fpHalf f, input logic s, input roundMode m);
		int     sig;
		int     eEff;
		int     sh;	// right shift to integer point
		int     mag;
		logic   up;
		intWord posLim;
		intWord negLim;
		posLim = s ? 16'h7FFF : 16'hFFFF;
		negLim = s ? 16'h8000 : 16'h0000;
		if (f.expo == 5'(expMax)) begin
			if (f.frac != '0)
				return posLim;	// nan
			return f.sign ? negLim : posLim;
		end
		sig  = int'(f.frac) + ((f.expo != 5'd0) ? (1 << (FMSB + 1)) : 0);
		eEff = (f.expo == 5'd0) ? 1 : int'(f.expo);
		sh   = expBias + FMSB + 1 - eEff;
		if (sh <= 0) begin
			mag = sig << (-sh);
		end else begin
			mag = sig >> sh;
			up  = roundUp(m, f.sign, mag[0], sig[sh-1], (sig & ((1 << (sh - 1)) - 1)) != 0);
			mag = mag + int'(up);
		end
		if (!f.sign)
			return (mag > int'(posLim)) ? posLim : 16'(mag);
		if (!s)
			return 16'h0000;	// negatives clamp when unsigned
		return (mag > 32768) ? negLim : 16'(-mag);
	endfunction

	// ==================================================
	// compare and drive helpers
	// ==================================================
	task automatic checkFloat(input string name, input fpHalf expV, input fpHalf act);
		if (act !== expV) begin
			errCount++;
			$display("Fail %s: expected %h actual %h", name, expV, act);
		end
	endtask

	task automatic checkInt(input string name, input intWord expV, input intWord act);
		if (act !== expV) begin
			errCount++;
			$display("Fail %s: expected %h actual %h", name, expV, act);
		end
	endtask

	// bounded wait for the edge that samples with ce high
	task automatic waitSampled(input string name);
		int   n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < 20) begin
			@(posedge clk);
			seen = ce;
			n++;
		end
		if (!seen) begin
			timeoutCount++;
			$display("%s: timed out waiting for a clock edge with ce high", name);
		end
	endtask

	task automatic convert(input string name, input cvtOp opV, input logic sV,
		input roundMode mV, input logic [15:0] aV);
		@(posedge clk);
		op  <= opV;
		sgn <= sV;
		rm  <= mV;
		a   <= aV;
		ce  <= 1'b1;
		waitSampled(name);
		ce <= 1'b0;
		#1;	// settle past the edge
	endtask

	task automatic runI2F(input string name, input logic sV, input roundMode mV, input intWord v);
		convert(name, opI2F, sV, mV, v);
		checkFloat(name, modelI2F(v, sV, mV), o);
	endtask

	task automatic runF2I(input string name, input logic sV, input roundMode mV, input fpHalf f);
		convert(name, opF2I, sV, mV, f);
		checkInt(name, modelF2I(f, sV, mV), o);
	endtask

	// ==================================================
	// directed tests
	// ==================================================
	task automatic testExactI2F;
		convert("exact 0", opI2F, 1'b0, rmNearEven, 16'd0);
		checkFloat("exact 0", 16'h0000, o);
		convert("exact 1", opI2F, 1'b0, rmNearEven, 16'd1);
		checkFloat("exact 1", 16'h3C00, o);
		convert("exact -1", opI2F, 1'b1, rmNearEven, 16'hFFFF);
		checkFloat("exact -1", 16'hBC00, o);
		convert("exact 1024", opI2F, 1'b0, rmNearEven, 16'd1024);
		checkFloat("exact 1024", 16'h6400, o);
		convert("exact 2048", opI2F, 1'b0, rmNearEven, 16'd2048);
		checkFloat("exact 2048", 16'h6800, o);
		convert("exact -32768", opI2F, 1'b1, rmNearEven, 16'h8000);
		checkFloat("exact -32768", 16'hF800, o);
	endtask

	task automatic testRoundI2F;
		intWord   vals[3] = '{16'd2049, 16'd2051, 16'hF7FD};	// last is -2051
		roundMode m;
		for (int k = 0; k < 5; k++) begin
			m = roundMode'(3'(k));
			foreach (vals[j])
				runI2F($sformatf("i2f round %h mode %0d", vals[j], k), 1'b1, m, vals[j]);
			// 65535 carries into the exponent and is inf unless truncating
			convert($sformatf("i2f 65535 mode %0d", k), opI2F, 1'b0, m, 16'hFFFF);
			checkFloat($sformatf("i2f 65535 mode %0d", k),
				(m == rmZero || m == rmNegInf) ? 16'h7BFF : 16'h7C00, o);
		end
	endtask

	task automatic testF2I;
		fpHalf vals[4] = '{16'h3E00, 16'h4100, 16'hC100, 16'h3400};	// 1.5 2.5 -2.5 0.25
		for (int k = 0; k < 5; k++) begin
			foreach (vals[j]) begin
				runF2I($sformatf("f2i %h mode %0d s", vals[j], k), 1'b1, roundMode'(3'(k)), vals[j]);
				runF2I($sformatf("f2i %h mode %0d u", vals[j], k), 1'b0, roundMode'(3'(k)), vals[j]);
			end
		end
	endtask

	task automatic testSaturation;
		// large finite, above int16, below int16, +inf, -inf, nan, -1.5
		fpHalf vals[7] = '{16'h7BFF, 16'h7A00, 16'hFA00, 16'h7C00, 16'hFC00, 16'h7E00,
			16'hBE00};
		foreach (vals[j]) begin
			runF2I($sformatf("sat %h s", vals[j]), 1'b1, rmNearEven, vals[j]);
			runF2I($sformatf("sat %h u", vals[j]), 1'b0, rmNearEven, vals[j]);
		end
	endtask

	// one random operand per call with opcode alternating on k
	task automatic driveRandom(input int k, output logic [15:0] expV, output cvtOp opV);
		logic [31:0] r;
		logic        sV;
		roundMode    mV;
		rngState = xorshift32(rngState);
		r   = rngState;
		opV = cvtOp'(k[0]);
		sV  = r[16];
		mV  = roundMode'(3'(r[31:24] % 8'd5));
		expV = (opV == opI2F) ? modelI2F(r[15:0], sV, mV) : modelF2I(r[15:0], sV, mV);
		op  <= opV;
		sgn <= sV;
		rm  <= mV;
		a   <= r[15:0];
		ce  <= 1'b1;
	endtask

	task automatic testStream;
		logic [15:0] expCur;
		logic [15:0] expChk;
		cvtOp        opCur;
		cvtOp        opChk;
		logic [15:0] held;
		@(posedge clk);
		driveRandom(0, expCur, opCur);
		for (int k = 0; k < 24; k++) begin
			waitSampled("stream");
			expChk = expCur;
			opChk  = opCur;
			if (k < 23)
				driveRandom(k + 1, expCur, opCur);	// next operand on the same edge
			else
				ce <= 1'b0;
			#1;
			if (opChk == opI2F)
				checkFloat($sformatf("stream %0d", k), expChk, o);
			else
				checkInt($sformatf("stream %0d", k), expChk, o);
		end
		held = o;
		for (int k = 0; k < 6; k++) begin	// output frozen while ce is low
			@(posedge clk);
			#1;
			checkInt("hold", held, o);
		end
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		errCount     = 0;
		timeoutCount = 0;
		rngState     = 32'd71846;
		arstN <= 1'b0;
		ce    <= 1'b0;
		op    <= opI2F;
		sgn   <= 1'b0;
		rm    <= rmNearEven;
		a     <= '0;
		repeat (16) @(posedge clk);
		arstN <= 1'b1;
		@(posedge clk);
		#1;
		checkInt("reset", '0, o);
		testExactI2F;
		testRoundI2F;
		testF2I;
		testSaturation;
		testStream;
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			errCount, timeoutCount, u_dut.uChk.failCount);
		if (errCount + timeoutCount + u_dut.uChk.failCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== fp16CvtUnit.sv ====
`timescale 1ns/1ps

module fp16CvtUnit import fp16Pkg::*; (
	input  logic             clk,
	input  logic             arstN,
	input  logic             ce,	// sample strobe and low holds
	input  cvtOp             op,
	input  logic             sgn,	// integer side is signed
	input  roundMode         rm,
	input  logic [FPWID-1:0] a,	// int or half per op
	output logic [FPWID-1:0] o
);

	fpHalf  fo;	// from i2f
	intWord io;	// from f2i
	logic   opd;	// staged opcode

	// both paths see every operand and op only picks the result
	i2f16 uI2f (
		.clk(clk), .arstN(arstN), .ce(ce),
		.sgn(sgn), .rm(rm),
		.i(a),
		.o(fo)
	);

	f2i16 uF2i (
		.clk(clk), .arstN(arstN), .ce(ce),
		.sgn(sgn), .rm(rm),
		.i(a),
		.o(io)
	);

	// staged alongside the converter inputs and resets to opI2F
	delay1 #(.WID(1)) uOp (.clk(clk), .arstN(arstN), .ce(ce), .i(op), .o(opd));

	assign o = (cvtOp'(opd) == opF2I) ? io : fo;

endmodule

// ==== fp16CvtUnit_checker.sv ====
`timescale 1ns/1ps

module fp16CvtUnit_checker import fp16Pkg::*; (
	input logic             clk,
	input logic             arstN,
	input logic             ce,
	input cvtOp             op,
	input logic [FPWID-1:0] a,
	input logic [FPWID-1:0] o
);

	int failCount = 0;	// assertion failures seen by the testbench

	// ==================================================
	// reset and hold
	// ==================================================
	resetZero: assert property (@(posedge clk) !arstN |-> o == '0)
		else begin
			$error("result not zero during reset");
			failCount++;
		end

	// no sample means no change
	holdStable: assert property (@(posedge clk) disable iff (!arstN)
		!ce |=> $stable(o))
		else begin
			$error("result moved while ce was low");
			failCount++;
		end

	// zero integer converts to +0
	zeroIn: assert property (@(posedge clk) disable iff (!arstN)
		(ce && op == opI2F && a == '0) |=> o == '0)
		else begin
			$error("integer zero did not give float zero");
			failCount++;
		end

endmodule

// ==== fp16Pkg.sv ====
package fp16Pkg;

	// ==================================================
	// field widths
	// ==================================================
	localparam int FPWID   = 16;	// float and integer word
	localparam int MSB     = FPWID - 1;
	localparam int EMSB    = 4;	// top bit of exponent field
	localparam int FMSB    = 9;	// top bit of fraction field
	localparam int expBias = 15;
	localparam int expMax  = 31;	// all ones exponent for inf and nan
	localparam int fixFrac = expBias + FMSB;	// f2i fixed point fraction bits

	// codes 5..7 fall back to nearest even
	typedef enum logic [2:0] {
		rmNearEven = 3'd0,
		rmZero     = 3'd1,
		rmPosInf   = 3'd2,
		rmNegInf   = 3'd3,
		rmAway     = 3'd4
	} roundMode;

	typedef enum logic {
		opI2F = 1'b0,	// int -> half
		opF2I = 1'b1	// half -> int
	} cvtOp;

	typedef struct packed {
		logic            sign;
		logic [EMSB:0]   expo;
		logic [FMSB:0]   frac;
	} fpHalf;

	typedef logic [MSB:0] intWord;	// meaning set by the sgn flag

	// ==================================================
	// round-up decision shared by both directions
	// ==================================================
	function automatic logic roundUp(
		input roundMode rm,
		input logic     sign,	// sign of the value being rounded
		input logic     lsb,	// kept lsb
		input logic     rndBit,	// first dropped bit
		input logic     sticky	// or of everything below
	);
		logic anyDrop;
		anyDrop = rndBit | sticky;
		case (rm)
			rmZero:   roundUp = 1'b0;	// truncate
			rmPosInf: roundUp = anyDrop & ~sign;
			rmNegInf: roundUp = anyDrop & sign;
			rmAway:   roundUp = anyDrop;
			default:  roundUp = rndBit & (lsb | sticky);	// ties to even
		endcase
	endfunction

endpackage

// ==== i2f16.sv ====
`timescale 1ns/1ps

module i2f16 import fp16Pkg::*; (
	input  logic     clk,
	input  logic     arstN,
	input  logic     ce,
	input  logic     sgn,	// treat i as two's complement
	input  roundMode rm,
	input  intWord   i,
	output fpHalf    o
);

	logic [2:0]    rmd;	// staged mode
	logic          nz;	// staged nonzero flag
	logic [MSB:0]  imag1;	// magnitude before staging
	logic [MSB:0]  imag;
	logic          so;	// staged sign already gated by sgn
	logic [4:0]    lz;
	logic [EMSB:0] expN;	// exponent before rounding carry
	logic [MSB:0]  simag;	// normalized magnitude
	logic [FMSB:0] frac;
	logic          rnd;
	logic          carry;
	logic [FMSB:0] fracR;
	logic [EMSB:0] expR;

	assign imag1 = (sgn & i[MSB]) ? -i : i;	// -32768 maps to 0x8000

	// ==================================================
	// input stage
	// ==================================================
	delay1 #(.WID(3))     uRm   (.clk(clk), .arstN(arstN), .ce(ce), .i(rm),           .o(rmd));
	delay1 #(.WID(1))     uNz   (.clk(clk), .arstN(arstN), .ce(ce), .i(i != '0),      .o(nz));
	delay1 #(.WID(FPWID)) uMag  (.clk(clk), .arstN(arstN), .ce(ce), .i(imag1),        .o(imag));
	delay1 #(.WID(1))     uSign (.clk(clk), .arstN(arstN), .ce(ce), .i(sgn & i[MSB]), .o(so));
	cntlz16Reg            uLz   (.clk(clk), .arstN(arstN), .ce(ce), .i(imag1),        .o(lz));

	// ==================================================
	// normalize and round
	// ==================================================
	// hidden one lands in bit 15 with weight 2^(15-lz)
	assign expN  = nz ? (expBias[EMSB:0] + MSB[EMSB:0] - lz) : '0;
	assign simag = imag << lz;
	assign frac  = simag[MSB-1 -: FMSB+1];	// drop the hidden bit

	assign rnd = roundUp(roundMode'(rmd), so,
		simag[MSB-1-FMSB],	// kept lsb
		simag[MSB-2-FMSB],	// first dropped bit
		|simag[MSB-3-FMSB:0]);

	// on carry the fraction wraps to zero and the exponent takes it
	assign {carry, fracR} = {1'b0, frac} + {{(FMSB+1){1'b0}}, rnd};
	assign expR = expN + {{EMSB{1'b0}}, carry};	// 30 + 1 gives expMax which is inf

	assign o = {so, expR, fracR};

endmodule

// ==== list.f ====
fp16Pkg.sv
delay1.sv
cntlz16Reg.sv
i2f16.sv
f2i16.sv
fp16CvtUnit.sv
fp16CvtUnit_checker.sv
fp16CvtTb.sv
